//--- hw/blk_pkg.sv
/* Block Hadamard shared definitions
   Geometry of the 8x8 block, sample and coefficient types, serializer states */
package blk_pkg;

	localparam int BLK_DIM = 8; // Samples per row and rows per block
	localparam int BLK_SAMPLES = BLK_DIM * BLK_DIM;
	localparam int SAMPLE_W = 8;
	localparam int COEF_W = 16; // 8 terms of 255 need 12 bits signed
	localparam int SAMP_IDX_W = $clog2(BLK_SAMPLES);
	localparam int ROW_IDX_W = $clog2(BLK_DIM);

	localparam int ROW_LAST = BLK_DIM - 1;
	localparam int SAMP_LAST = BLK_SAMPLES - 1;

	// Pixel sample as it arrives on the input strobe
	typedef logic [SAMPLE_W-1:0] sample_t;

	// Transform coefficient, two's complement
	typedef logic signed [COEF_W-1:0] coef_t;

	typedef logic [SAMP_IDX_W-1:0] samp_idx_t; // Position inside a block
	typedef logic [ROW_IDX_W-1:0]  row_idx_t;

	// One row of samples, sample 0 in the low byte
	typedef logic [BLK_DIM*SAMPLE_W-1:0] row_samples_t;

	// One row of coefficients, coefficient 0 in the low word
	typedef logic [BLK_DIM*COEF_W-1:0] row_coefs_t;

	typedef enum logic [1:0]
	{
		SER_IDLE,
		SER_LOAD,
		SER_EMIT
	} ser_state_t;

endpackage

//--- hw/sample_collector.sv
/* Sample collector
   Stores strobed pixel samples of one 8x8 block in row-major order,
   pulses block_ready once the 64th sample is in and serves rows by index */
module sample_collector
	import blk_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         sample_en,
	input  sample_t      sample,
	input  logic         frame_sync,
	input  row_idx_t     row_sel,
	output row_samples_t row_data,
	output logic         block_ready
);

	sample_t   sample_mem [BLK_SAMPLES]; // Block buffer, row-major
	samp_idx_t wr_cnt;
	logic      wr_en;
	logic      last_sample;

	// Restart takes priority over a sample in the same cycle
	assign wr_en = sample_en && !frame_sync;

	assign last_sample = wr_en && (wr_cnt == samp_idx_t'(SAMP_LAST));

	// Sample count
	always_ff @(posedge clk)
	begin
		if (!rst_n || frame_sync)
			wr_cnt <= '0;
		else if (wr_en)
			wr_cnt <= wr_cnt + 1'b1; // Wraps to 0 after the 64th sample
	end

	// Storage only, old contents are simply overwritten
	always_ff @(posedge clk)
	begin
		if (wr_en)
			sample_mem[wr_cnt] <= sample;
	end

	// One-cycle pulse in the cycle after the 64th sample is stored
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			block_ready <= 1'b0;
		else
			block_ready <= last_sample;
	end

	// Row read port
	always_comb
	begin
		row_data = '0;
		for (int j = 0; j < BLK_DIM; j++)
		begin
			// Column index has the same width as the row index
			row_data[j*SAMPLE_W +: SAMPLE_W] = sample_mem[{row_sel, row_idx_t'(j)}];
		end
	end

endmodule

//--- hw/row_hadamard.sv
/* Row transform
   Walks the eight rows of a collected block and applies an 8-point
   Walsh-Hadamard transform to each, one registered row per cycle */
module row_hadamard
	import blk_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         block_ready,
	output row_idx_t     row_sel,
	input  row_samples_t row_data,
	output logic         row_wr,
	output row_idx_t     row_wr_idx,
	output row_coefs_t   row_coefs,
	output logic         rows_done
);

	logic       busy;
	row_idx_t   row_cnt;
	logic       row_last;
	row_coefs_t stage0;
	row_coefs_t stage1;
	row_coefs_t stage2;
	row_coefs_t stage3;

	// One butterfly pass with the given span
	// Pairs (i, i+span) become (a+b, a-b), lower index gets the sum
	function automatic row_coefs_t butterfly(input row_coefs_t v, input int span);
		row_coefs_t r;
		coef_t      a;
		coef_t      b;
		r = v;
		for (int i = 0; i < BLK_DIM; i++)
		begin
			if ((i & span) == 0)
			begin
				a = v[i*COEF_W +: COEF_W];
				b = v[(i+span)*COEF_W +: COEF_W];
				r[i*COEF_W +: COEF_W] = a + b;
				r[(i+span)*COEF_W +: COEF_W] = a - b;
			end
		end
		return r;
	endfunction

	assign row_sel = row_cnt;
	assign row_last = (row_cnt == row_idx_t'(ROW_LAST));

	// Row sequencer, starts the cycle after block_ready
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			row_cnt <= '0;
		end
		else if (block_ready)
		begin
			busy <= 1'b1;
			row_cnt <= '0;
		end
		else if (busy)
		begin
			row_cnt <= row_cnt + 1'b1; // Back to 0 after row 7
			if (row_last)
				busy <= 1'b0;
		end
	end

	// Zero-extend bytes into signed words
	always_comb
	begin
		stage0 = '0;
		for (int j = 0; j < BLK_DIM; j++)
		begin
			stage0[j*COEF_W +: COEF_W] = coef_t'({{(COEF_W-SAMPLE_W){1'b0}},
				row_data[j*SAMPLE_W +: SAMPLE_W]});
		end
	end

	// Spans 1, 2, 4 give natural (Hadamard) ordering
	assign stage1 = butterfly(stage0, 1);
	assign stage2 = butterfly(stage1, 2);
	assign stage3 = butterfly(stage2, BLK_DIM / 2);

	// Write strobes to the serializer
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			row_wr <= 1'b0;
			rows_done <= 1'b0;
		end
		else
		begin
			row_wr <= busy;
			rows_done <= busy && row_last; // With the row 7 write
		end
	end

	// Row result and its index
	always_ff @(posedge clk)
	begin
		if (busy)
		begin
			row_wr_idx <= row_cnt;
			row_coefs <= stage3;
		end
	end

endmodule

//--- hw/coef_serializer.sv
/* Coefficient serializer
   Buffers the eight transformed rows of a block and streams the 64
   coefficients out one per cycle in row-major order */
module coef_serializer
	import blk_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       row_wr,
	input  row_idx_t   row_wr_idx,
	input  row_coefs_t row_coefs,
	input  logic       rows_done,
	output coef_t      coef,
	output logic       coef_valid,
	output logic       block_done
);

	coef_t      coef_mem [BLK_SAMPLES];
	ser_state_t state;
	ser_state_t state_nxt;
	samp_idx_t  rd_ptr;
	logic       rd_last;
	logic       store;

	// Rows are accepted until the block is complete
	assign store = row_wr && (state != SER_EMIT);
	assign rd_last = (rd_ptr == samp_idx_t'(SAMP_LAST));

	always_comb
	begin
		state_nxt = state;
		case (state)
			SER_IDLE:
			begin
				if (row_wr)
					state_nxt = SER_LOAD; // First row of a block
			end
			SER_LOAD:
			begin
				if (rows_done)
					state_nxt = SER_EMIT;
			end
			SER_EMIT:
			begin
				if (rd_last)
					state_nxt = SER_IDLE;
			end
			default: state_nxt = SER_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= SER_IDLE;
		else
			state <= state_nxt;
	end

	// Read pointer runs only while emitting
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			rd_ptr <= '0;
		else if (state == SER_EMIT)
			rd_ptr <= rd_ptr + 1'b1; // Wraps to 0 with the last entry
		else
			rd_ptr <= '0;
	end

	// Whole row written per strobe
	always_ff @(posedge clk)
	begin
		if (store)
		begin
			for (int j = 0; j < BLK_DIM; j++)
				coef_mem[{row_wr_idx, row_idx_t'(j)}] <= row_coefs[j*COEF_W +: COEF_W];
		end
	end

	assign coef = coef_mem[rd_ptr];
	assign coef_valid = (state == SER_EMIT);
	assign block_done = coef_valid && rd_last; // With the 64th coefficient

endmodule

//--- hw/block_hadamard.sv
/* 8x8 block row Hadamard transform
   Sample collector, row transform and coefficient serializer in series */
module block_hadamard
	import blk_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    sample_en,
	input  sample_t sample,
	input  logic    frame_sync,
	output coef_t   coef,
	output logic    coef_valid,
	output logic    block_done
);

	// Collector to transform
	logic         block_ready;
	row_idx_t     row_sel;
	row_samples_t row_data;

	// Transform to serializer
	logic         row_wr;
	row_idx_t     row_wr_idx;
	row_coefs_t   row_coefs;
	logic         rows_done;

	sample_collector sample_collector_inst
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.sample_en   (sample_en),
		.sample      (sample),
		.frame_sync  (frame_sync),
		.row_sel     (row_sel),
		.row_data    (row_data),
		.block_ready (block_ready)
	);

	row_hadamard row_hadamard_inst
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.block_ready (block_ready),
		.row_sel     (row_sel),
		.row_data    (row_data),
		.row_wr      (row_wr),
		.row_wr_idx  (row_wr_idx),
		.row_coefs   (row_coefs),
		.rows_done   (rows_done)
	);

	coef_serializer coef_serializer_inst
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.row_wr      (row_wr),
		.row_wr_idx  (row_wr_idx),
		.row_coefs   (row_coefs),
		.rows_done   (rows_done),
		.coef        (coef),
		.coef_valid  (coef_valid),
		.block_done  (block_done)
	);

endmodule

//--- testbench/block_hadamard_props.sv
/* Protocol assertions for the block Hadamard top level
   Reset state, output burst length, block_done framing, sender gap */
module block_hadamard_props
(
	input logic clk,
	input logic rst_n,
	input logic sample_en,
	input logic block_ready,
	input logic row_wr,
	input logic rows_done,
	input logic coef_valid,
	input logic block_done
);
	timeunit 1ns;
	timeprecision 1ps;

	int run_len; // Consecutive coef_valid cycles so far
	int quiet_cnt; // Remaining cycles with no sample allowed
	int fail_reset = 0;
	int fail_len = 0;
	int fail_done = 0;
	int fail_quiet = 0;
	int fail_cnt;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			run_len <= 0;
			quiet_cnt <= 0;
		end
		else
		begin
			run_len <= coef_valid ? run_len + 1 : 0;
			if (block_ready)
				quiet_cnt <= 7; // block_ready cycle plus 7 more
			else if (quiet_cnt > 0)
				quiet_cnt <= quiet_cnt - 1;
		end
	end

	always_comb fail_cnt = fail_reset + fail_len + fail_done + fail_quiet;

	a_reset_quiet: assert property (@(posedge clk)
		!rst_n |=> !(block_ready || row_wr || rows_done || coef_valid || block_done))
		else begin fail_reset++; $error("control output high after a reset cycle"); end

	a_burst_end: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(coef_valid) |-> run_len == 64)
		else begin fail_len++; $error("coef_valid burst ended after %0d cycles", run_len); end

	a_burst_max: assert property (@(posedge clk) disable iff (!rst_n)
		coef_valid |-> run_len < 64)
		else begin fail_len++; $error("coef_valid burst longer than 64 cycles"); end

	// Only on the 64th cycle of a burst
	a_done_framed: assert property (@(posedge clk) disable iff (!rst_n)
		block_done |-> coef_valid && run_len == 63)
		else begin fail_done++; $error("block_done outside the last cycle of a burst"); end

	a_sender_gap: assert property (@(posedge clk) disable iff (!rst_n)
		(block_ready || quiet_cnt > 0) |-> !sample_en)
		else begin fail_quiet++; $error("sample_en inside the idle gap after a block"); end

endmodule

bind block_hadamard block_hadamard_props props_inst
(
	.clk (clk), .rst_n (rst_n), .sample_en (sample_en), .block_ready (block_ready),
	.row_wr (row_wr), .rows_done (rows_done), .coef_valid (coef_valid),
	.block_done (block_done)
);

//--- testbench/block_hadamard_tb.sv
/* Testbench for the 8x8 block row Hadamard transform
   Sends blocks from the test file and checks coefficients and latency */
module block_hadamard_tb
	import blk_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT = 1000; // Cycles to wait for a block's output
	localparam int LATENCY = 10;
	localparam int ROW_TOKENS = 2 * BLK_DIM; // Bytes then coefficients
	localparam int BLOCK_TOKENS = 2 + BLK_DIM * ROW_TOKENS;

	logic        clk;
	logic        rst_n;
	logic        sample_en;
	sample_t     sample;
	logic        frame_sync;
	coef_t       coef;
	logic        coef_valid;
	logic        block_done;
	logic [15:0] tvec [0:511];
	logic [31:0] lcg_state;
	int          n_blocks;
	int          errors = 0;
	int          timeouts = 0;
	int          cyc = 0; // Rising edges since start
	int          e0_q [$]; // Edge count of each block's last sample

	block_hadamard block_hadamard_inst
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.sample_en  (sample_en),
		.sample     (sample),
		.frame_sync (frame_sync),
		.coef       (coef),
		.coef_valid (coef_valid),
		.block_done (block_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic compare_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic finish_run();
		int afails;
		afails = block_hadamard_inst.props_inst.fail_cnt;
		$display("Done: %0d errors, %0d timeouts, %0d assertion failures",
			errors, timeouts, afails);
		if (errors == 0 && timeouts == 0 && afails == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	endtask

	// Called on a falling edge, returns one falling edge later
	task automatic put_sample(input sample_t s);
		sample_en = 1'b1;
		sample = s;
		@(negedge clk);
		sample_en = 1'b0;
	endtask

	task automatic send_block(input int b);
		int base;
		base = 1 + b * BLOCK_TOKENS;
		for (int i = 0; i < int'(tvec[base]); i++)
			put_sample(sample_t'(i + 160)); // Partial block, dropped by frame_sync
		if (tvec[base] != 0)
		begin
			frame_sync = 1'b1;
			@(negedge clk);
			frame_sync = 1'b0;
		end
		for (int i = 0; i < BLK_SAMPLES; i++)
		begin
			if (tvec[base + 1] != 0 && i > 0)
			begin
				lcg_state = lcg_next(lcg_state);
				repeat (int'(lcg_state[18:16])) @(negedge clk);
			end
			if (i == BLK_SAMPLES - 1)
				e0_q.push_back(cyc + 1); // Next rising edge stores it
			put_sample(sample_t'(tvec[base + 2 + (i / BLK_DIM) * ROW_TOKENS + (i % BLK_DIM)]));
		end
		repeat (8) @(negedge clk); // Minimum idle gap
	endtask

	task automatic check_block(input int b);
		int base;
		int waited;
		int e0;
		base = 1 + b * BLOCK_TOKENS;
		waited = 0;
		while (!coef_valid && waited < TIMEOUT)
		begin
			compare_value("block_done", 16'(block_done), 16'd0);
			@(negedge clk);
			waited++;
		end
		if (!coef_valid)
		begin
			timeouts++;
			$display("Timeout: no coef_valid for block %0d within %0d cycles", b, TIMEOUT);
			finish_run();
		end
		else
		begin
			if (e0_q.size() == 0)
			begin
				errors++;
				$display("coef_valid rose at %0t before any complete block was sent", $time);
			end
			else
			begin
				e0 = e0_q.pop_front();
				compare_value("latency", 16'(cyc - e0), 16'(LATENCY));
			end
			for (int i = 0; i < BLK_SAMPLES; i++)
			begin
				compare_value("coef_valid", 16'(coef_valid), 16'd1);
				compare_value("coef", coef,
					tvec[base + 2 + (i / BLK_DIM) * ROW_TOKENS + BLK_DIM + (i % BLK_DIM)]);
				compare_value("block_done", 16'(block_done), 16'(i == BLK_SAMPLES - 1));
				@(negedge clk);
			end
			compare_value("coef_valid", 16'(coef_valid), 16'd0); // Burst is over
		end
	endtask

	initial
	begin
		rst_n = 1'b0;
		sample_en = 1'b0;
		sample = '0;
		frame_sync = 1'b0;
		lcg_state = 32'hed56;
		$readmemh("testbench/block_hadamard_tests.txt", tvec);
		n_blocks = int'(tvec[0]);
		if ($isunknown(tvec[0]) || n_blocks == 0)
		begin
			errors++;
			$display("Test file is missing or holds no blocks");
		end
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		fork
			for (int b = 0; b < n_blocks; b++)
				send_block(b);
			for (int b = 0; b < n_blocks; b++)
				check_block(b);
		join
		finish_run();
	end

endmodule

//--- block_hadamard.f
hw/blk_pkg.sv
hw/sample_collector.sv
hw/row_hadamard.sv
hw/coef_serializer.sv
hw/block_hadamard.sv
testbench/block_hadamard_props.sv
testbench/block_hadamard_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = block_hadamard_tb
FILELIST  = block_hadamard.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SIM_ARGS  = +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "RESULT: FAIL" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/block_hadamard_tests.txt
// Block count, then per block: samples before frame_sync, gap mode
// then 8 rows of 8 input bytes and 8 expected coefficients, all hex
3
0 0
00 01 02 03 04 05 06 07 001c fffc fff8 0000 fff0 0000 0000 0000
08 09 0a 0b 0c 0d 0e 0f 005c fffc fff8 0000 fff0 0000 0000 0000
10 11 12 13 14 15 16 17 009c fffc fff8 0000 fff0 0000 0000 0000
18 19 1a 1b 1c 1d 1e 1f 00dc fffc fff8 0000 fff0 0000 0000 0000
20 21 22 23 24 25 26 27 011c fffc fff8 0000 fff0 0000 0000 0000
28 29 2a 2b 2c 2d 2e 2f 015c fffc fff8 0000 fff0 0000 0000 0000
30 31 32 33 34 35 36 37 019c fffc fff8 0000 fff0 0000 0000 0000
38 39 3a 3b 3c 3d 3e 3f 01dc fffc fff8 0000 fff0 0000 0000 0000
5 0
ff ff ff ff ff ff ff ff 07f8 0000 0000 0000 0000 0000 0000 0000
ff ff ff ff ff ff ff ff 07f8 0000 0000 0000 0000 0000 0000 0000
ff ff ff ff ff ff ff ff 07f8 0000 0000 0000 0000 0000 0000 0000
ff ff ff ff ff ff ff ff 07f8 0000 0000 0000 0000 0000 0000 0000
ff ff ff ff ff ff ff ff 07f8 0000 0000 0000 0000 0000 0000 0000
ff ff ff ff ff ff ff ff 07f8 0000 0000 0000 0000 0000 0000 0000
ff ff ff ff ff ff ff ff 07f8 0000 0000 0000 0000 0000 0000 0000
ff ff ff ff ff ff ff ff 07f8 0000 0000 0000 0000 0000 0000 0000
0 1
00 01 02 03 04 05 06 07 001c fffc fff8 0000 fff0 0000 0000 0000
08 09 0a 0b 0c 0d 0e 0f 005c fffc fff8 0000 fff0 0000 0000 0000
10 11 12 13 14 15 16 17 009c fffc fff8 0000 fff0 0000 0000 0000
18 19 1a 1b 1c 1d 1e 1f 00dc fffc fff8 0000 fff0 0000 0000 0000
20 21 22 23 24 25 26 27 011c fffc fff8 0000 fff0 0000 0000 0000
28 29 2a 2b 2c 2d 2e 2f 015c fffc fff8 0000 fff0 0000 0000 0000
30 31 32 33 34 35 36 37 019c fffc fff8 0000 fff0 0000 0000 0000
38 39 3a 3b 3c 3d 3e 3f 01dc fffc fff8 0000 fff0 0000 0000 0000
